//--- hdl/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// datapath widths
`define DATA_WIDTH      32
`define INST_WIDTH      32
`define REG_ADDR_BITS   5
`define PC_BITS         10
`define DMEM_ADDR_BITS  6
`define OPCODE_BITS     6

// instruction fields
`define OPCODE_MSB      31
`define OPCODE_LSB      26
`define RS_MSB          25
`define RS_LSB          21
`define RT_MSB          20
`define RT_LSB          16
`define RD_MSB          15
`define RD_LSB          11
`define IMM_MSB         15
`define IMM_LSB         0

`endif

//--- hdl/pipe_pkg.sv
`include "pipe_settings.svh"

package pipe_pkg;

  // anything not listed decodes as nop
  typedef enum logic [`OPCODE_BITS-1:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_slt  = 6'd5,
    op_addi = 6'd6,
    op_lw   = 6'd7,
    op_sw   = 6'd8,
    op_beq  = 6'd9
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  typedef enum logic [1:0] {
    fwd_reg,
    fwd_ex_mem,
    fwd_mem_wb
  } fwd_sel_t;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src_imm;
    logic    branch;
    logic    dest_is_rd;
    alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    logic                   valid;
    logic [`PC_BITS-1:0]    pc;
    logic [`INST_WIDTH-1:0] instruction;
  } if_id_t;

  typedef struct packed {
    logic                      valid;
    ctrl_t                     ctrl;
    logic [`PC_BITS-1:0]       pc;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [`REG_ADDR_BITS-1:0] dest;
    logic [`DATA_WIDTH-1:0]    rs_data;
    logic [`DATA_WIDTH-1:0]    rt_data;
    logic [`DATA_WIDTH-1:0]    imm;
  } id_ex_t;

  typedef struct packed {
    logic                      valid;
    ctrl_t                     ctrl;
    logic [`DATA_WIDTH-1:0]    result;
    logic [`DATA_WIDTH-1:0]    store_data;
    logic [`REG_ADDR_BITS-1:0] dest;
  } ex_mem_t;

  // r0 is never a real destination
  function automatic logic writes_reg(logic valid, ctrl_t ctrl,
                                      logic [`REG_ADDR_BITS-1:0] dest);
    return valid && ctrl.reg_write && (dest != '0);
  endfunction

endpackage

//--- hdl/bypass_if.sv
`include "pipe_settings.svh"

interface bypass_if;

  // result leaving execute
  logic                      ex_mem_write;
  logic [`REG_ADDR_BITS-1:0] ex_mem_rd;
  logic [`DATA_WIDTH-1:0]    ex_mem_value;

  // result at writeback, also the register file write port
  logic                      mem_wb_write;
  logic [`REG_ADDR_BITS-1:0] mem_wb_rd;
  logic [`DATA_WIDTH-1:0]    mem_wb_value;

  modport ex_side (output ex_mem_write, ex_mem_rd, ex_mem_value);
  modport wb_side (output mem_wb_write, mem_wb_rd, mem_wb_value);
  modport fwd_sink (input ex_mem_write, ex_mem_rd, ex_mem_value,
                    input mem_wb_write, mem_wb_rd, mem_wb_value);
  modport rf_sink (input mem_wb_write, mem_wb_rd, mem_wb_value);

endinterface

//--- hdl/reg_file.sv
`include "pipe_settings.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`REG_ADDR_BITS-1:0] rs_addr,
  input  logic [`REG_ADDR_BITS-1:0] rt_addr,
  output logic [`DATA_WIDTH-1:0]    rs_data,
  output logic [`DATA_WIDTH-1:0]    rt_data,
  input  logic                      write,
  input  logic [`REG_ADDR_BITS-1:0] write_addr,
  input  logic [`DATA_WIDTH-1:0]    write_data
);

  logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_BITS];

  // same-cycle write is seen by the read
  function automatic logic [`DATA_WIDTH-1:0] read_port(logic [`REG_ADDR_BITS-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (write && write_addr == addr) begin
      return write_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**`REG_ADDR_BITS; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[write_addr] <= write_data;
    end
  end

  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

endmodule

//--- hdl/forward_unit.sv
`include "pipe_settings.svh"

module forward_unit import pipe_pkg::*; (
  input  logic [`REG_ADDR_BITS-1:0] rs,
  input  logic [`REG_ADDR_BITS-1:0] rt,
  bypass_if.fwd_sink                byp,
  output fwd_sel_t                  fwd_a,
  output fwd_sel_t                  fwd_b
);

  // younger result wins
  function automatic fwd_sel_t source(logic [`REG_ADDR_BITS-1:0] src,
                                      logic ex_write, logic [`REG_ADDR_BITS-1:0] ex_rd,
                                      logic wb_write, logic [`REG_ADDR_BITS-1:0] wb_rd);
    if (ex_write && ex_rd == src) begin
      return fwd_ex_mem;
    end else if (wb_write && wb_rd == src) begin
      return fwd_mem_wb;
    end
    return fwd_reg;
  endfunction

  always_comb begin
    fwd_a = source(rs, byp.ex_mem_write, byp.ex_mem_rd, byp.mem_wb_write, byp.mem_wb_rd);
    fwd_b = source(rt, byp.ex_mem_write, byp.ex_mem_rd, byp.mem_wb_write, byp.mem_wb_rd);
  end

endmodule

//--- hdl/fetch_stage.sv
`include "pipe_settings.svh"

module fetch_stage import pipe_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  output logic [`PC_BITS-1:0]    imem_addr,
  input  logic [`INST_WIDTH-1:0] imem_data,
  input  logic                   load_use_stall,
  input  logic                   redirect,
  input  logic [`PC_BITS-1:0]    redirect_pc,
  output if_id_t                 if_id
);

  logic [`PC_BITS-1:0]    pc;
  // request in flight, answered this cycle
  logic [`PC_BITS-1:0]    req_pc;
  logic                   req_valid;
  // word that came back while decode was stalled
  logic                   held;
  logic [`INST_WIDTH-1:0] held_inst;

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= '0;
      req_valid <= 1'b0;
      held      <= 1'b0;
    end else if (redirect) begin
      pc        <= redirect_pc;
      req_valid <= 1'b0;
      held      <= 1'b0;
    end else if (load_use_stall) begin
      held <= 1'b1;
    end else begin
      pc        <= pc + 1'b1;
      req_valid <= 1'b1;
      held      <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!load_use_stall) begin
      req_pc <= pc;
    end
    if (load_use_stall && !held) begin
      held_inst <= imem_data;
    end
  end

  ////////////////////////////////////////
  // if/id

  always_ff @(posedge clk) begin
    if (reset) begin
      if_id.valid <= 1'b0;
    end else if (redirect) begin
      if_id.valid <= 1'b0;
    end else if (!load_use_stall) begin
      if_id.valid       <= req_valid;
      if_id.pc          <= req_pc;
      if_id.instruction <= held ? held_inst : imem_data;
    end
  end

  // the refetched word must come from the same address
  stall_holds_addr: assert property (
    @(posedge clk) disable iff (reset)
    load_use_stall && !redirect |=> $stable(imem_addr)
  ) else $error("fetch address moved across a load-use stall");

endmodule

//--- hdl/decode_stage.sv
`include "pipe_settings.svh"

module decode_stage import pipe_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  if_id_t     if_id,
  input  logic       redirect,
  bypass_if.rf_sink  rf,
  output logic       load_use_stall,
  output id_ex_t     id_ex
);

  opcode_t                   opcode;
  logic [`REG_ADDR_BITS-1:0] rs;
  logic [`REG_ADDR_BITS-1:0] rt;
  logic [`REG_ADDR_BITS-1:0] rd;
  logic [`IMM_MSB:`IMM_LSB]  imm;
  logic [`DATA_WIDTH-1:0]    imm_ext;
  logic [`DATA_WIDTH-1:0]    rs_data;
  logic [`DATA_WIDTH-1:0]    rt_data;
  ctrl_t                     ctrl;

  assign opcode  = opcode_t'(if_id.instruction[`OPCODE_MSB:`OPCODE_LSB]);
  assign rs      = if_id.instruction[`RS_MSB:`RS_LSB];
  assign rt      = if_id.instruction[`RT_MSB:`RT_LSB];
  assign rd      = if_id.instruction[`RD_MSB:`RD_LSB];
  assign imm     = if_id.instruction[`IMM_MSB:`IMM_LSB];
  // sign extended so branches can go backwards
  assign imm_ext = {{(`DATA_WIDTH - `IMM_MSB - 1){imm[`IMM_MSB]}}, imm};

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = alu_add;
    case (opcode)
      op_add: {ctrl.reg_write, ctrl.dest_is_rd} = 2'b11;
      op_sub: begin
        {ctrl.reg_write, ctrl.dest_is_rd} = 2'b11;
        ctrl.alu_op = alu_sub;
      end
      op_and: begin
        {ctrl.reg_write, ctrl.dest_is_rd} = 2'b11;
        ctrl.alu_op = alu_and;
      end
      op_or: begin
        {ctrl.reg_write, ctrl.dest_is_rd} = 2'b11;
        ctrl.alu_op = alu_or;
      end
      op_slt: begin
        {ctrl.reg_write, ctrl.dest_is_rd} = 2'b11;
        ctrl.alu_op = alu_slt;
      end
      op_addi: {ctrl.reg_write, ctrl.alu_src_imm} = 2'b11;
      op_lw:   {ctrl.reg_write, ctrl.mem_read, ctrl.alu_src_imm} = 3'b111;
      op_sw:   {ctrl.mem_write, ctrl.alu_src_imm} = 2'b11;
      op_beq:  ctrl.branch = 1'b1;
      default: ;
    endcase
  end

  reg_file u_rf (
    .clk        (clk),
    .reset      (reset),
    .rs_addr    (rs),
    .rt_addr    (rt),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .write      (rf.mem_wb_write),
    .write_addr (rf.mem_wb_rd),
    .write_data (rf.mem_wb_value)
  );

  // loaded value is not ready until the load leaves memory
  assign load_use_stall = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read &&
                          (id_ex.dest != '0) && (id_ex.dest == rs || id_ex.dest == rt);

  ////////////////////////////////////////
  // id/ex

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.valid <= 1'b0;
    end else if (redirect || load_use_stall) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.valid   <= if_id.valid;
      id_ex.ctrl    <= ctrl;
      id_ex.pc      <= if_id.pc;
      id_ex.rs      <= rs;
      id_ex.rt      <= rt;
      id_ex.dest    <= ctrl.dest_is_rd ? rd : rt;
      id_ex.rs_data <= rs_data;
      id_ex.rt_data <= rt_data;
      id_ex.imm     <= imm_ext;
    end
  end

  // stalled word stays in if/id while execute gets a bubble
  stall_holds_if_id: assert property (
    @(posedge clk) disable iff (reset)
    load_use_stall && !redirect |=> !id_ex.valid && $stable(if_id)
  ) else $error("load-use stall did not hold if/id or insert a bubble");

endmodule

//--- hdl/execute_stage.sv
`include "pipe_settings.svh"

module execute_stage import pipe_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  id_ex_t              id_ex,
  bypass_if.ex_side           byp,
  bypass_if.fwd_sink          byp_fwd,
  output logic                redirect,
  output logic [`PC_BITS-1:0] redirect_pc,
  output ex_mem_t             ex_mem
);

  fwd_sel_t               fwd_a;
  fwd_sel_t               fwd_b;
  logic [`DATA_WIDTH-1:0] op_a;
  logic [`DATA_WIDTH-1:0] rt_value;
  logic [`DATA_WIDTH-1:0] op_b;
  logic [`DATA_WIDTH-1:0] alu_result;

  function automatic logic [`DATA_WIDTH-1:0] pick(fwd_sel_t sel,
                                                  logic [`DATA_WIDTH-1:0] reg_value,
                                                  logic [`DATA_WIDTH-1:0] ex_value,
                                                  logic [`DATA_WIDTH-1:0] wb_value);
    case (sel)
      fwd_ex_mem: return ex_value;
      fwd_mem_wb: return wb_value;
      default:    return reg_value;
    endcase
  endfunction

  forward_unit u_fwd (
    .rs    (id_ex.rs),
    .rt    (id_ex.rt),
    .byp   (byp_fwd),
    .fwd_a (fwd_a),
    .fwd_b (fwd_b)
  );

  assign op_a     = pick(fwd_a, id_ex.rs_data, byp_fwd.ex_mem_value, byp_fwd.mem_wb_value);
  assign rt_value = pick(fwd_b, id_ex.rt_data, byp_fwd.ex_mem_value, byp_fwd.mem_wb_value);
  assign op_b     = id_ex.ctrl.alu_src_imm ? id_ex.imm : rt_value;

  always_comb begin
    alu_result = op_a + op_b;
    case (id_ex.ctrl.alu_op)
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_slt: begin
        alu_result = '0;
        alu_result[0] = $signed(op_a) < $signed(op_b);
      end
      default: ;
    endcase
  end

  // beq resolves here, target is relative to the next word
  assign redirect    = id_ex.valid && id_ex.ctrl.branch && (op_a == rt_value);
  assign redirect_pc = id_ex.pc + 1'b1 + id_ex.imm[`PC_BITS-1:0];

  ////////////////////////////////////////
  // ex/mem

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.result     <= alu_result;
      ex_mem.store_data <= rt_value;
      ex_mem.dest       <= id_ex.dest;
    end
  end

  assign byp.ex_mem_write = writes_reg(ex_mem.valid, ex_mem.ctrl, ex_mem.dest);
  assign byp.ex_mem_rd    = ex_mem.dest;
  assign byp.ex_mem_value = ex_mem.result;

endmodule

//--- hdl/memory_stage.sv
`include "pipe_settings.svh"

module memory_stage import pipe_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  ex_mem_t                   ex_mem,
  bypass_if.wb_side                 byp,
  output logic                      wb_valid,
  output logic [`REG_ADDR_BITS-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]    wb_data
);

  logic [`DATA_WIDTH-1:0]    dmem [2**`DMEM_ADDR_BITS];
  logic [`DMEM_ADDR_BITS-1:0] addr;
  logic [`DATA_WIDTH-1:0]    load_data;

  // word address, upper result bits ignored
  assign addr      = ex_mem.result[`DMEM_ADDR_BITS-1:0];
  assign load_data = dmem[addr];

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.ctrl.mem_write) begin
      dmem[addr] <= ex_mem.store_data;
    end
  end

  ////////////////////////////////////////
  // mem/wb

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= writes_reg(ex_mem.valid, ex_mem.ctrl, ex_mem.dest);
      wb_reg   <= ex_mem.dest;
      wb_data  <= ex_mem.ctrl.mem_read ? load_data : ex_mem.result;
    end
  end

  assign byp.mem_wb_write = wb_valid;
  assign byp.mem_wb_rd    = wb_reg;
  assign byp.mem_wb_value = wb_data;

  no_r0_retire: assert property (
    @(posedge clk) disable iff (reset)
    wb_valid |-> wb_reg != '0
  ) else $error("writeback strobe for r0");

endmodule

//--- hdl/pipe_core.sv
`include "pipe_settings.svh"

module pipe_core import pipe_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  output logic [`PC_BITS-1:0]       imem_addr,
  input  logic [`INST_WIDTH-1:0]    imem_data,
  output logic                      wb_valid,
  output logic [`REG_ADDR_BITS-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]    wb_data
);

  if_id_t              if_id;
  id_ex_t              id_ex;
  ex_mem_t             ex_mem;
  logic                load_use_stall;
  logic                redirect;
  logic [`PC_BITS-1:0] redirect_pc;

  bypass_if u_byp ();

  fetch_stage u_fetch (
    .clk            (clk),
    .reset          (reset),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .load_use_stall (load_use_stall),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .if_id          (if_id)
  );

  decode_stage u_decode (
    .clk            (clk),
    .reset          (reset),
    .if_id          (if_id),
    .redirect       (redirect),
    .rf             (u_byp),
    .load_use_stall (load_use_stall),
    .id_ex          (id_ex)
  );

  execute_stage u_execute (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .byp         (u_byp),
    .byp_fwd     (u_byp),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_mem      (ex_mem)
  );

  memory_stage u_memory (
    .clk      (clk),
    .reset    (reset),
    .ex_mem   (ex_mem),
    .byp      (u_byp),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data)
  );

endmodule

//--- verif/pipe_core_tb.sv
`include "pipe_settings.svh"

module pipe_core_tb import pipe_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // program lengths: alu 32, dependency 6, load/store 9, branch 9, r0 6
  localparam int TOTAL_LEN   = 62;
  localparam int CYCLE_LIMIT = 8 * TOTAL_LEN + 100;

  logic                      clk;
  logic                      reset;
  logic [`PC_BITS-1:0]       imem_addr;
  logic [`INST_WIDTH-1:0]    imem_data;
  logic                      wb_valid;
  logic [`REG_ADDR_BITS-1:0] wb_reg;
  logic [`DATA_WIDTH-1:0]    wb_data;

  logic [`INST_WIDTH-1:0]    prog [2**`PC_BITS];
  logic [`DATA_WIDTH-1:0]    dmem_model [2**`DMEM_ADDR_BITS];
  logic [36:0]               exp_q [$];
  logic                      head_valid;
  logic [`REG_ADDR_BITS-1:0] head_reg;
  logic [`DATA_WIDTH-1:0]    head_data;
  logic [31:0]               lfsr;
  int                        prog_len;
  int                        errors;
  int                        cycles;
  int                        tests_run;
  int                        tests_failed;
  string                     test_name;

  pipe_core u_dut (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // instruction memory answers one cycle later
  always @(posedge clk) begin
    imem_data <= prog[imem_addr];
  end

  // head of the expected queue as seen during the strobe cycle
  always @(posedge clk) begin
    if (!reset && wb_valid && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
    end
    head_valid <= exp_q.size() != 0;
    if (exp_q.size() != 0) begin
      head_reg  <= exp_q[0][36:32];
      head_data <= exp_q[0][31:0];
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: test %s did not finish within %0d cycles", test_name, CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////
  // checks

  reset_state: assert property (
    @(posedge clk) reset |=> imem_addr == '0 && !wb_valid
  ) else begin
    $display("Error: %s fetch address not zero or strobe high after reset", test_name);
    errors++;
  end

  strobe_expected: assert property (
    @(posedge clk) disable iff (reset) wb_valid |-> head_valid
  ) else begin
    $display("Error: %s writeback strobe for r%0d with no result expected",
             test_name, $sampled(wb_reg));
    errors++;
  end

  strobe_value: assert property (
    @(posedge clk) disable iff (reset)
    wb_valid && head_valid |-> wb_reg == head_reg && wb_data == head_data
  ) else begin
    $display("Error: %s expected r%0d=%h actual r%0d=%h", test_name,
             $sampled(head_reg), $sampled(head_data), $sampled(wb_reg), $sampled(wb_data));
    errors++;
  end

  ////////////////////////////////////////
  // stimulus helpers

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic logic [31:0] encode(opcode_t op, int rs, int rt, int rd_or_imm);
    logic [31:0] w;
    w = {op, rs[4:0], rt[4:0], rd_or_imm[15:0]};
    if (op inside {op_add, op_sub, op_and, op_or, op_slt}) begin
      w[15:0] = {rd_or_imm[4:0], 11'd0};
    end
    return w;
  endfunction

  task automatic emit(logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic start_program();
    for (int i = 0; i < 2**`PC_BITS; i++) begin
      prog[i] = '0;
    end
    prog_len = 0;
  endtask

  // walks the program in order and queues each register write
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] res;
    int          pc;
    int          dest;
    logic        wr;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = 0;
    for (int steps = 0; steps < 200; steps++) begin
      inst = prog[pc];
      if (inst == encode(op_beq, 0, 0, 16'hffff)) break;
      a    = regs[inst[25:21]];
      b    = regs[inst[20:16]];
      simm = {{16{inst[15]}}, inst[15:0]};
      wr   = 1'b1;
      dest = inst[15:11];
      res  = '0;
      case (opcode_t'(inst[31:26]))
        op_add:  res = a + b;
        op_sub:  res = a - b;
        op_and:  res = a & b;
        op_or:   res = a | b;
        op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        op_addi: begin
          res  = a + simm;
          dest = inst[20:16];
        end
        op_lw: begin
          res  = dmem_model[(a + simm) % 64];
          dest = inst[20:16];
        end
        op_sw: begin
          dmem_model[(a + simm) % 64] = b;
          wr = 1'b0;
        end
        default: wr = 1'b0;
      endcase
      if (wr && dest != 0) begin
        regs[dest] = res;
        exp_q.push_back({dest[4:0], res});
      end
      if (opcode_t'(inst[31:26]) == op_beq && a == b) begin
        pc = (pc + 1 + int'(simm)) & 1023;
      end else begin
        pc = pc + 1;
      end
    end
  endtask

  task automatic run_test(string name);
    int errors_before;
    emit(encode(op_beq, 0, 0, 16'hffff));
    test_name     = name;
    errors_before = errors;
    exp_q.delete();
    run_model();
    @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // extra strobes after the last expected one are caught here
    repeat (12) @(posedge clk);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: fail", name);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // test sections

  initial begin
    int base;
    reset     = 1'b1;
    imem_data = '0;
    lfsr      = 32'h4b5c_5f9f;
    errors    = 0;
    cycles    = 0;
    tests_run = 0;
    tests_failed = 0;
    test_name = "reset";

    start_program();
    for (int r = 1; r < 8; r++) begin
      emit(encode(op_addi, 0, r, rand_bits(16)));
    end
    for (int i = 0; i < 24; i++) begin
      case (rand_bits(3) % 6)
        0: emit(encode(op_add, rand_bits(3), rand_bits(3), rand_bits(3)));
        1: emit(encode(op_sub, rand_bits(3), rand_bits(3), rand_bits(3)));
        2: emit(encode(op_and, rand_bits(3), rand_bits(3), rand_bits(3)));
        3: emit(encode(op_or, rand_bits(3), rand_bits(3), rand_bits(3)));
        4: emit(encode(op_slt, rand_bits(3), rand_bits(3), rand_bits(3)));
        default: emit(encode(op_addi, rand_bits(3), rand_bits(3), rand_bits(16)));
      endcase
    end
    run_test("alu_random");

    // distances 1, 2 and 3 to the producer
    start_program();
    emit(encode(op_addi, 0, 1, rand_bits(16)));
    emit(encode(op_addi, 1, 2, rand_bits(16)));
    emit(encode(op_sub, 1, 2, 3));
    emit(encode(op_and, 1, 3, 4));
    emit(encode(op_slt, 4, 2, 5));
    run_test("dependency");

    start_program();
    base = rand_bits(6) % 62;
    emit(encode(op_addi, 0, 1, base));
    emit(encode(op_addi, 0, 2, rand_bits(16)));
    emit(encode(op_sw, 1, 2, 0));
    emit(encode(op_lw, 1, 3, 0));
    emit(encode(op_add, 3, 3, 4));
    emit(encode(op_sw, 1, 4, 1));
    emit(encode(op_lw, 1, 5, 1));
    emit(encode(op_addi, 5, 6, 1));
    run_test("load_store");

    // taken branch skips two, the second one falls through
    start_program();
    emit(encode(op_addi, 0, 1, 3));
    emit(encode(op_addi, 0, 2, 3));
    emit(encode(op_beq, 1, 2, 2));
    emit(encode(op_addi, 0, 3, rand_bits(16)));
    emit(encode(op_addi, 0, 4, rand_bits(16)));
    emit(encode(op_addi, 0, 5, rand_bits(16)));
    emit(encode(op_beq, 1, 0, 1));
    emit(encode(op_addi, 0, 6, rand_bits(16)));
    run_test("branch");

    start_program();
    emit(encode(op_addi, 0, 0, 5));
    emit(encode(op_add, 0, 0, 1));
    emit(encode(op_addi, 0, 2, rand_bits(16)));
    emit(encode(op_add, 2, 2, 0));
    emit(encode(op_or, 0, 2, 3));
    run_test("zero_reg");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- pipe_core.f
+incdir+hdl
hdl/pipe_pkg.sv
hdl/bypass_if.sv
hdl/reg_file.sv
hdl/forward_unit.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/pipe_core.sv
verif/pipe_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module pipe_core_tb \
  -f pipe_core.f \
  -o sim_pipe_core

./obj_dir/sim_pipe_core > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  exit 1
fi
exit 0
